// File: source/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;
  localparam int word_addr_w = xlen - 2; // Byte offset dropped, word buses only
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0] word_t;
  typedef logic [word_addr_w-1:0] waddr_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_jal      = 7'b1101111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_cmd_t;

  // Same codes as the branch funct3
  typedef enum logic [2:0] {
    cmp_eq  = 3'b000,
    cmp_ne  = 3'b001,
    cmp_lt  = 3'b100,
    cmp_ge  = 3'b101,
    cmp_ltu = 3'b110,
    cmp_geu = 3'b111
  } cmp_cmd_t;

endpackage

// File: source/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
  parameter rv_pkg::waddr_t reset_pc = '0
) (
  input wire logic clk_i,
  input wire logic reset_ni,

  input wire logic redirect_valid_i,
  input wire rv_pkg::waddr_t redirect_pc_i,

  input wire logic ready_i,
  output logic valid_o,
  output rv_pkg::word_t instr_o,
  output rv_pkg::waddr_t pc_o,

  input wire logic ibus_ack_i,
  input wire logic ibus_stall_i,
  input wire rv_pkg::word_t ibus_data_i,
  output rv_pkg::waddr_t ibus_addr_o,
  output logic ibus_cyc_o,
  output logic ibus_stb_o
);

  rv_pkg::waddr_t pc_q;
  logic discard_q; // Pending ack belongs to a stale request

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      pc_q <= reset_pc;
    end else if (redirect_valid_i) begin
      pc_q <= redirect_pc_i;
    end else if (valid_o && ready_i) begin
      pc_q <= pc_q + 1'b1;
    end
  end

  // One word per bus cycle
  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      ibus_cyc_o <= 1'b0;
      ibus_stb_o <= 1'b0;
      discard_q <= 1'b0;
    end else if (ibus_cyc_o) begin
      if (!ibus_stall_i) begin
        ibus_stb_o <= 1'b0;
      end
      if (ibus_ack_i) begin
        ibus_cyc_o <= 1'b0;
        ibus_stb_o <= 1'b0;
        discard_q <= 1'b0;
      end else if (redirect_valid_i) begin
        discard_q <= 1'b1;
      end
    end else if (!valid_o) begin
      ibus_cyc_o <= 1'b1;
      ibus_stb_o <= 1'b1;
      ibus_addr_o <= redirect_valid_i ? redirect_pc_i : pc_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_ni || redirect_valid_i) begin
      valid_o <= 1'b0;
    end else if (ibus_cyc_o && ibus_ack_i && !discard_q) begin
      valid_o <= 1'b1;
    end else if (ready_i) begin
      valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ibus_cyc_o && ibus_ack_i) begin
      instr_o <= ibus_data_i;
      pc_o <= ibus_addr_o;
    end
  end

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!reset_ni)
    ibus_stb_o |-> ibus_cyc_o);

  addr_held: assert property (@(posedge clk_i) disable iff (!reset_ni)
    ibus_stb_o && ibus_stall_i |=> $stable(ibus_addr_o));

endmodule

// File: source/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input wire logic clk_i,
  input wire logic reset_ni,
  input wire logic clear_i, // Taken branch in execute

  input wire logic valid_i,
  output logic ready_o,
  input wire rv_pkg::word_t instr_i,
  input wire rv_pkg::waddr_t pc_i,

  input wire logic ready_i,
  input wire rv_pkg::reg_addr_t ex_rd_i,
  input wire rv_pkg::reg_addr_t mem_rd_i,
  input wire rv_pkg::reg_addr_t wb_rd_i,

  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  input wire rv_pkg::word_t rs1_data_i,
  input wire rv_pkg::word_t rs2_data_i,

  output logic valid_o,
  output rv_pkg::waddr_t pc_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::alu_cmd_t alu_cmd_o,
  output rv_pkg::word_t alu_lhs_o,
  output rv_pkg::word_t alu_rhs_o,
  output rv_pkg::cmp_cmd_t cmp_cmd_o,
  output rv_pkg::word_t cmp_lhs_o,
  output rv_pkg::word_t cmp_rhs_o,
  output logic branch_o,
  output logic mem_o,
  output logic mem_we_o,
  output rv_pkg::word_t store_data_o
);

  rv_pkg::opcode_t opcode;
  logic [2:0] funct3;
  rv_pkg::word_t i_imm, s_imm, b_imm, u_imm, j_imm, pc_byte;
  rv_pkg::reg_addr_t rd_d;
  rv_pkg::alu_cmd_t alu_cmd_d;
  rv_pkg::word_t alu_lhs_d, alu_rhs_d, cmp_lhs_d, cmp_rhs_d;
  rv_pkg::cmp_cmd_t cmp_cmd_d;
  logic branch_d, mem_d, mem_we_d, use_rs1, use_rs2, stall;

  function automatic logic hazard(rv_pkg::reg_addr_t rs);
    return rs != '0 && (rs == ex_rd_i || rs == mem_rd_i || rs == wb_rd_i);
  endfunction

  assign opcode = rv_pkg::opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];
  assign pc_byte = {pc_i, 2'b00};

  assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
  assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign b_imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign u_imm = {instr_i[31:12], 12'b0};
  assign j_imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  assign stall = hazard(use_rs1 ? rs1_o : '0) || hazard(use_rs2 ? rs2_o : '0);
  assign ready_o = ready_i && !stall;

  always_comb begin
    case (funct3)
      3'b001:  alu_cmd_d = rv_pkg::alu_sll;
      3'b010:  alu_cmd_d = rv_pkg::alu_slt;
      3'b011:  alu_cmd_d = rv_pkg::alu_sltu;
      3'b100:  alu_cmd_d = rv_pkg::alu_xor;
      3'b101:  alu_cmd_d = instr_i[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  alu_cmd_d = rv_pkg::alu_or;
      3'b111:  alu_cmd_d = rv_pkg::alu_and;
      default: alu_cmd_d = rv_pkg::alu_add;
    endcase
    cmp_cmd_d = (funct3[2:1] == 2'b01) ? rv_pkg::cmp_eq : rv_pkg::cmp_cmd_t'(funct3);
    alu_lhs_d = rs1_data_i;
    alu_rhs_d = rs2_data_i;
    cmp_lhs_d = rs1_data_i;
    cmp_rhs_d = rs2_data_i;
    rd_d = '0;
    {branch_d, mem_d, mem_we_d, use_rs1, use_rs2} = '0;

    case (opcode)
      rv_pkg::opc_lui, rv_pkg::opc_auipc: begin
        alu_cmd_d = rv_pkg::alu_add;
        alu_lhs_d = u_imm;
        alu_rhs_d = (opcode == rv_pkg::opc_auipc) ? pc_byte : '0;
        rd_d = instr_i[11:7];
      end
      rv_pkg::opc_op_imm: begin
        alu_rhs_d = i_imm;
        rd_d = instr_i[11:7];
        use_rs1 = 1'b1;
      end
      rv_pkg::opc_op: begin
        if (funct3 == 3'b000 && instr_i[30]) alu_cmd_d = rv_pkg::alu_sub;
        rd_d = instr_i[11:7];
        {use_rs1, use_rs2} = 2'b11;
      end
      rv_pkg::opc_jal: begin // Always taken through eq on zeros
        alu_cmd_d = rv_pkg::alu_add;
        alu_lhs_d = pc_byte;
        alu_rhs_d = j_imm;
        cmp_cmd_d = rv_pkg::cmp_eq;
        cmp_lhs_d = '0;
        cmp_rhs_d = '0;
        branch_d = 1'b1;
        rd_d = instr_i[11:7];
      end
      rv_pkg::opc_branch: begin
        alu_cmd_d = rv_pkg::alu_add;
        alu_lhs_d = pc_byte;
        alu_rhs_d = b_imm;
        branch_d = 1'b1;
        {use_rs1, use_rs2} = 2'b11;
      end
      rv_pkg::opc_load, rv_pkg::opc_store: begin
        alu_cmd_d = rv_pkg::alu_add;
        mem_d = 1'b1;
        use_rs1 = 1'b1;
        if (opcode == rv_pkg::opc_store) begin
          alu_rhs_d = s_imm;
          {mem_we_d, use_rs2} = 2'b11;
        end else begin
          alu_rhs_d = i_imm;
          rd_d = instr_i[11:7];
        end
      end
      rv_pkg::opc_misc_mem, rv_pkg::opc_system: ; // No-ops
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_ni || clear_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end else if (ready_i) begin
      valid_o <= 1'b0; // Bubble behind a hazard
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      pc_o <= pc_i;
      rd_o <= rd_d;
      alu_cmd_o <= alu_cmd_d;
      alu_lhs_o <= alu_lhs_d;
      alu_rhs_o <= alu_rhs_d;
      cmp_cmd_o <= cmp_cmd_d;
      cmp_lhs_o <= cmp_lhs_d;
      cmp_rhs_o <= cmp_rhs_d;
      branch_o <= branch_d;
      mem_o <= mem_d;
      mem_we_o <= mem_we_d;
      store_data_o <= rs2_data_i;
    end
  end

  no_valid_after_clear: assert property (@(posedge clk_i) disable iff (!reset_ni)
    clear_i |=> !valid_o);

endmodule

// File: source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input wire logic clk_i,

  input wire rv_pkg::reg_addr_t rs1_i,
  input wire rv_pkg::reg_addr_t rs2_i,
  output rv_pkg::word_t rs1_data_o,
  output rv_pkg::word_t rs2_data_o,

  input wire logic we_i,
  input wire rv_pkg::reg_addr_t rd_i,
  input wire rv_pkg::word_t rd_data_i
);

  rv_pkg::word_t regs [2**rv_pkg::reg_addr_w];

  // x0 reads zero whatever the array holds
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

  always_ff @(posedge clk_i) begin
    if (we_i && rd_i != '0) begin
      regs[rd_i] <= rd_data_i;
    end
  end

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input wire logic clk_i,
  input wire logic reset_ni,

  input wire logic valid_i,
  output logic ready_o,
  input wire rv_pkg::waddr_t pc_i,
  input wire rv_pkg::reg_addr_t rd_i,
  input wire rv_pkg::alu_cmd_t alu_cmd_i,
  input wire rv_pkg::word_t alu_lhs_i,
  input wire rv_pkg::word_t alu_rhs_i,
  input wire rv_pkg::cmp_cmd_t cmp_cmd_i,
  input wire rv_pkg::word_t cmp_lhs_i,
  input wire rv_pkg::word_t cmp_rhs_i,
  input wire logic branch_i,
  input wire logic mem_i,
  input wire logic mem_we_i,
  input wire rv_pkg::word_t store_data_i,

  input wire logic ready_i,
  output logic valid_o,
  output rv_pkg::waddr_t pc_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::word_t result_o,
  output logic mem_o,
  output logic mem_we_o,
  output rv_pkg::word_t store_data_o,

  output logic redirect_valid_o,
  output rv_pkg::waddr_t redirect_pc_o,
  output rv_pkg::reg_addr_t hz_rd_o
);

  rv_pkg::word_t alu_res;
  logic cmp_res;
  logic taken;

  assign ready_o = ready_i;
  assign hz_rd_o = valid_i ? rd_i : '0;
  // Whatever follows a taken branch is on the wrong path
  assign taken = valid_i && branch_i && cmp_res && !redirect_valid_o;

  always_comb begin
    case (alu_cmd_i)
      rv_pkg::alu_sub:  alu_res = alu_lhs_i - alu_rhs_i;
      rv_pkg::alu_sll:  alu_res = alu_lhs_i << alu_rhs_i[4:0];
      rv_pkg::alu_slt:  alu_res = {31'b0, $signed(alu_lhs_i) < $signed(alu_rhs_i)};
      rv_pkg::alu_sltu: alu_res = {31'b0, alu_lhs_i < alu_rhs_i};
      rv_pkg::alu_xor:  alu_res = alu_lhs_i ^ alu_rhs_i;
      rv_pkg::alu_srl:  alu_res = alu_lhs_i >> alu_rhs_i[4:0];
      rv_pkg::alu_sra:  alu_res = $signed(alu_lhs_i) >>> alu_rhs_i[4:0];
      rv_pkg::alu_or:   alu_res = alu_lhs_i | alu_rhs_i;
      rv_pkg::alu_and:  alu_res = alu_lhs_i & alu_rhs_i;
      default:          alu_res = alu_lhs_i + alu_rhs_i;
    endcase

    case (cmp_cmd_i)
      rv_pkg::cmp_ne:  cmp_res = cmp_lhs_i != cmp_rhs_i;
      rv_pkg::cmp_lt:  cmp_res = $signed(cmp_lhs_i) < $signed(cmp_rhs_i);
      rv_pkg::cmp_ge:  cmp_res = $signed(cmp_lhs_i) >= $signed(cmp_rhs_i);
      rv_pkg::cmp_ltu: cmp_res = cmp_lhs_i < cmp_rhs_i;
      rv_pkg::cmp_geu: cmp_res = cmp_lhs_i >= cmp_rhs_i;
      default:         cmp_res = cmp_lhs_i == cmp_rhs_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      valid_o <= 1'b0;
      redirect_valid_o <= 1'b0;
    end else begin
      redirect_valid_o <= ready_o && taken; // One cycle pulse
      if (ready_o) begin
        valid_o <= valid_i && !redirect_valid_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      pc_o <= pc_i;
      rd_o <= rd_i;
      result_o <= branch_i ? {pc_i, 2'b00} + 32'd4 : alu_res; // Link value
      mem_o <= mem_i;
      mem_we_o <= mem_we_i;
      store_data_o <= store_data_i;
      redirect_pc_o <= alu_res[rv_pkg::xlen-1:2];
    end
  end

endmodule

// File: source/rv_mem.sv
`timescale 1ns/1ps

module rv_mem (
  input wire logic clk_i,
  input wire logic reset_ni,

  input wire logic valid_i,
  output logic ready_o,
  input wire rv_pkg::waddr_t pc_i,
  input wire rv_pkg::reg_addr_t rd_i,
  input wire rv_pkg::word_t result_i,
  input wire logic mem_i,
  input wire logic mem_we_i,
  input wire rv_pkg::word_t store_data_i,
  output rv_pkg::reg_addr_t hz_rd_o,

  output logic wb_valid_o,
  output rv_pkg::reg_addr_t wb_rd_o,
  output rv_pkg::word_t wb_data_o,

  input wire logic dbus_ack_i,
  input wire logic dbus_stall_i,
  input wire rv_pkg::word_t dbus_data_i,
  output rv_pkg::waddr_t dbus_addr_o,
  output rv_pkg::word_t dbus_data_o,
  output logic [3:0] dbus_sel_o,
  output logic dbus_we_o,
  output logic dbus_cyc_o,
  output logic dbus_stb_o
);

  rv_pkg::reg_addr_t rd_q;
  logic accept;

  assign ready_o = !dbus_cyc_o;
  assign accept = valid_i && ready_o;
  assign dbus_sel_o = 4'b1111; // Word accesses only
  assign wb_rd_o = wb_valid_o ? rd_q : '0;
  assign hz_rd_o = dbus_cyc_o ? rd_q : (valid_i ? rd_i : '0); // Load in flight owns rd

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      dbus_cyc_o <= 1'b0;
      dbus_stb_o <= 1'b0;
      wb_valid_o <= 1'b0;
    end else if (dbus_cyc_o) begin
      if (!dbus_stall_i) begin
        dbus_stb_o <= 1'b0;
      end
      if (dbus_ack_i) begin
        dbus_cyc_o <= 1'b0;
        dbus_stb_o <= 1'b0;
        wb_valid_o <= 1'b1;
      end
    end else begin
      dbus_cyc_o <= accept && mem_i;
      dbus_stb_o <= accept && mem_i;
      wb_valid_o <= accept && !mem_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_q <= rd_i;
      wb_data_o <= result_i;
      dbus_addr_o <= result_i[rv_pkg::xlen-1:2];
      dbus_data_o <= store_data_i;
      dbus_we_o <= mem_we_i;
    end else if (dbus_cyc_o && dbus_ack_i) begin
      wb_data_o <= dbus_data_i;
    end
  end

  stb_in_cyc: assert property (@(posedge clk_i) disable iff (!reset_ni)
    dbus_stb_o |-> dbus_cyc_o);

  addr_held: assert property (@(posedge clk_i) disable iff (!reset_ni)
    dbus_stb_o && dbus_stall_i |=> $stable(dbus_addr_o));

  // Execute must hold its instruction while the bus is busy
  exe_held: assert property (@(posedge clk_i) disable iff (!reset_ni)
    valid_i && !ready_o |=> valid_i && $stable(pc_i));

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::waddr_t reset_pc = '0
) (
  input wire logic clk_i,
  input wire logic reset_ni,

  input wire logic ibus_ack_i,
  input wire logic ibus_stall_i,
  input wire rv_pkg::word_t ibus_data_i,
  output rv_pkg::waddr_t ibus_addr_o,
  output logic ibus_cyc_o,
  output logic ibus_stb_o,

  input wire logic dbus_ack_i,
  input wire logic dbus_stall_i,
  input wire rv_pkg::word_t dbus_data_i,
  output rv_pkg::waddr_t dbus_addr_o,
  output rv_pkg::word_t dbus_data_o,
  output logic [3:0] dbus_sel_o,
  output logic dbus_we_o,
  output logic dbus_cyc_o,
  output logic dbus_stb_o
);

  logic fetch_valid, fetch_ready;
  rv_pkg::word_t fetch_instr;
  rv_pkg::waddr_t fetch_pc;

  rv_pkg::reg_addr_t rs1, rs2;
  rv_pkg::word_t rs1_data, rs2_data;

  logic dec_valid, dec_ready, dec_branch, dec_mem, dec_mem_we;
  rv_pkg::waddr_t dec_pc;
  rv_pkg::reg_addr_t dec_rd;
  rv_pkg::alu_cmd_t dec_alu_cmd;
  rv_pkg::cmp_cmd_t dec_cmp_cmd;
  rv_pkg::word_t dec_alu_lhs, dec_alu_rhs, dec_cmp_lhs, dec_cmp_rhs, dec_store_data;

  logic exe_valid, exe_ready, exe_mem, exe_mem_we;
  rv_pkg::waddr_t exe_pc;
  rv_pkg::reg_addr_t exe_rd;
  rv_pkg::word_t exe_result, exe_store_data;

  logic redirect_valid;
  rv_pkg::waddr_t redirect_pc;
  rv_pkg::reg_addr_t hz_ex_rd, hz_mem_rd;

  logic wb_valid;
  rv_pkg::reg_addr_t wb_rd;
  rv_pkg::word_t wb_data;

  rv_fetch #(.reset_pc(reset_pc)) i_rv_fetch (
    .clk_i, .reset_ni,
    .redirect_valid_i(redirect_valid), .redirect_pc_i(redirect_pc),
    .ready_i(fetch_ready), .valid_o(fetch_valid),
    .instr_o(fetch_instr), .pc_o(fetch_pc),
    .ibus_ack_i, .ibus_stall_i, .ibus_data_i,
    .ibus_addr_o, .ibus_cyc_o, .ibus_stb_o
  );

  rv_decode i_rv_decode (
    .clk_i, .reset_ni, .clear_i(redirect_valid),
    .valid_i(fetch_valid), .ready_o(fetch_ready),
    .instr_i(fetch_instr), .pc_i(fetch_pc),
    .ready_i(dec_ready), .ex_rd_i(hz_ex_rd), .mem_rd_i(hz_mem_rd), .wb_rd_i(wb_rd),
    .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .valid_o(dec_valid), .pc_o(dec_pc), .rd_o(dec_rd),
    .alu_cmd_o(dec_alu_cmd), .alu_lhs_o(dec_alu_lhs), .alu_rhs_o(dec_alu_rhs),
    .cmp_cmd_o(dec_cmp_cmd), .cmp_lhs_o(dec_cmp_lhs), .cmp_rhs_o(dec_cmp_rhs),
    .branch_o(dec_branch), .mem_o(dec_mem), .mem_we_o(dec_mem_we),
    .store_data_o(dec_store_data)
  );

  // Writeback is the memory stage's result port
  rv_regfile i_rv_regfile (
    .clk_i,
    .rs1_i(rs1), .rs2_i(rs2), .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(wb_valid), .rd_i(wb_rd), .rd_data_i(wb_data)
  );

  rv_execute i_rv_execute (
    .clk_i, .reset_ni,
    .valid_i(dec_valid), .ready_o(dec_ready), .pc_i(dec_pc), .rd_i(dec_rd),
    .alu_cmd_i(dec_alu_cmd), .alu_lhs_i(dec_alu_lhs), .alu_rhs_i(dec_alu_rhs),
    .cmp_cmd_i(dec_cmp_cmd), .cmp_lhs_i(dec_cmp_lhs), .cmp_rhs_i(dec_cmp_rhs),
    .branch_i(dec_branch), .mem_i(dec_mem), .mem_we_i(dec_mem_we),
    .store_data_i(dec_store_data),
    .ready_i(exe_ready), .valid_o(exe_valid), .pc_o(exe_pc), .rd_o(exe_rd),
    .result_o(exe_result), .mem_o(exe_mem), .mem_we_o(exe_mem_we),
    .store_data_o(exe_store_data),
    .redirect_valid_o(redirect_valid), .redirect_pc_o(redirect_pc), .hz_rd_o(hz_ex_rd)
  );

  rv_mem i_rv_mem (
    .clk_i, .reset_ni,
    .valid_i(exe_valid), .ready_o(exe_ready), .pc_i(exe_pc), .rd_i(exe_rd),
    .result_i(exe_result), .mem_i(exe_mem), .mem_we_i(exe_mem_we),
    .store_data_i(exe_store_data), .hz_rd_o(hz_mem_rd),
    .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
    .dbus_ack_i, .dbus_stall_i, .dbus_data_i,
    .dbus_addr_o, .dbus_data_o, .dbus_sel_o, .dbus_we_o, .dbus_cyc_o, .dbus_stb_o
  );

endmodule

// File: sim/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam rv_pkg::waddr_t reset_pc = 30'h40; // Byte address 0x100
  localparam int timeout_cycles = 400;
  localparam logic [11:0] bad_off = 12'h7f0; // Target of stores that must never run

  logic clk_i;
  logic reset_ni;
  logic ibus_ack_i, ibus_stall_i;
  rv_pkg::word_t ibus_data_i;
  rv_pkg::waddr_t ibus_addr_o;
  logic ibus_cyc_o, ibus_stb_o;
  logic dbus_ack_i, dbus_stall_i;
  rv_pkg::word_t dbus_data_i;
  rv_pkg::waddr_t dbus_addr_o;
  rv_pkg::word_t dbus_data_o;
  logic [3:0] dbus_sel_o;
  logic dbus_we_o, dbus_cyc_o, dbus_stb_o;

  integer seed = 14180;
  rv_pkg::word_t prog[$];
  rv_pkg::waddr_t exp_addr[$];
  rv_pkg::word_t exp_data[$];
  rv_pkg::waddr_t got_addr[$];
  rv_pkg::word_t got_data[$];
  rv_pkg::word_t dmem [rv_pkg::waddr_t];
  logic [11:0] store_off = 12'h200;

  logic ipend, dpend, dwe;
  logic [1:0] idelay, ddelay;
  rv_pkg::waddr_t iaddr, daddr;
  rv_pkg::word_t dwdata;

  rv_core #(.reset_pc(reset_pc)) i_rv_core (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic rv_pkg::word_t r_type(logic [6:0] f7, rv_pkg::reg_addr_t rs2,
      rv_pkg::reg_addr_t rs1, logic [2:0] f3, rv_pkg::reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::opc_op};
  endfunction

  function automatic rv_pkg::word_t i_type(logic [11:0] imm, rv_pkg::reg_addr_t rs1,
      logic [2:0] f3, rv_pkg::reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t s_type(rv_pkg::reg_addr_t rs2, rv_pkg::reg_addr_t rs1,
      logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::opc_store};
  endfunction

  function automatic rv_pkg::word_t b_type(logic [12:0] imm, rv_pkg::reg_addr_t rs2,
      rv_pkg::reg_addr_t rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::opc_branch};
  endfunction

  function automatic rv_pkg::word_t u_type(logic [19:0] imm, rv_pkg::reg_addr_t rd,
      logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic rv_pkg::word_t j_type(logic [20:0] imm, rv_pkg::reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::opc_jal};
  endfunction

  // Known word at every data address until it is written
  function automatic rv_pkg::word_t fill_word(rv_pkg::waddr_t a);
    return {2'b00, a} ^ ({2'b00, a} << 16) ^ 32'h5a5a0000;
  endfunction

  function automatic rv_pkg::word_t pc_now();
    return {reset_pc, 2'b00} + 32'(prog.size() * 4);
  endfunction

  task automatic store_and_expect(rv_pkg::reg_addr_t rs, rv_pkg::word_t value);
    prog.push_back(s_type(rs, 5'd0, store_off));
    exp_addr.push_back(30'(store_off >> 2));
    exp_data.push_back(value);
    store_off = store_off + 12'd4;
  endtask

  // Marker in x15 is 1 when the branch skips the second write
  task automatic branch_case(logic [2:0] f3, rv_pkg::reg_addr_t rs1, rv_pkg::reg_addr_t rs2,
      logic taken);
    prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd15, rv_pkg::opc_op_imm));
    prog.push_back(b_type(13'd8, rs2, rs1, f3));
    prog.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd15, rv_pkg::opc_op_imm));
    store_and_expect(5'd15, taken ? 32'd1 : 32'd2);
  endtask

  task automatic build_program();
    rv_pkg::word_t link;
    prog.push_back(i_type(12'd100, 5'd0, 3'b000, 5'd1, rv_pkg::opc_op_imm)); // x1 = 100
    prog.push_back(i_type(12'hff9, 5'd0, 3'b000, 5'd2, rv_pkg::opc_op_imm)); // x2 = -7
    prog.push_back(i_type(12'd4, 5'd0, 3'b000, 5'd10, rv_pkg::opc_op_imm));
    store_and_expect(5'd1, 32'd100);
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
    store_and_expect(5'd3, 32'h0000005d);
    prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
    store_and_expect(5'd4, 32'h0000006b);
    prog.push_back(r_type(7'h20, 5'd1, 5'd2, 3'b000, 5'd4));
    store_and_expect(5'd4, 32'hffffff95);
    prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd5)); // slt
    store_and_expect(5'd5, 32'd1);
    prog.push_back(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd5)); // sltu
    store_and_expect(5'd5, 32'd0);
    prog.push_back(i_type(12'hffa, 5'd2, 3'b010, 5'd5, rv_pkg::opc_op_imm));
    store_and_expect(5'd5, 32'd1);
    prog.push_back(i_type(12'hfff, 5'd1, 3'b011, 5'd5, rv_pkg::opc_op_imm));
    store_and_expect(5'd5, 32'd1);
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd6));
    store_and_expect(5'd6, 32'hffffff9d);
    prog.push_back(i_type(12'h00f, 5'd1, 3'b100, 5'd6, rv_pkg::opc_op_imm));
    store_and_expect(5'd6, 32'h0000006b);
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd7));
    store_and_expect(5'd7, 32'hfffffffd);
    prog.push_back(i_type(12'h003, 5'd1, 3'b110, 5'd7, rv_pkg::opc_op_imm));
    store_and_expect(5'd7, 32'h00000067);
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd8));
    store_and_expect(5'd8, 32'h00000060);
    prog.push_back(i_type(12'h0f0, 5'd2, 3'b111, 5'd8, rv_pkg::opc_op_imm));
    store_and_expect(5'd8, 32'h000000f0);
    prog.push_back(r_type(7'h00, 5'd10, 5'd1, 3'b001, 5'd9)); // Shifts by x10 = 4
    store_and_expect(5'd9, 32'h00000640);
    prog.push_back(i_type(12'h008, 5'd2, 3'b001, 5'd9, rv_pkg::opc_op_imm));
    store_and_expect(5'd9, 32'hfffff900);
    prog.push_back(r_type(7'h00, 5'd10, 5'd2, 3'b101, 5'd9));
    store_and_expect(5'd9, 32'h0fffffff);
    prog.push_back(i_type(12'h01c, 5'd2, 3'b101, 5'd9, rv_pkg::opc_op_imm));
    store_and_expect(5'd9, 32'h0000000f);
    prog.push_back(r_type(7'h20, 5'd10, 5'd2, 3'b101, 5'd9));
    store_and_expect(5'd9, 32'hffffffff);
    prog.push_back(i_type(12'h401, 5'd2, 3'b101, 5'd9, rv_pkg::opc_op_imm)); // srai 1
    store_and_expect(5'd9, 32'hfffffffc);
    prog.push_back(u_type(20'h12345, 5'd11, rv_pkg::opc_lui));
    store_and_expect(5'd11, 32'h12345000);
    link = pc_now() + 32'h1000;
    prog.push_back(u_type(20'h00001, 5'd12, rv_pkg::opc_auipc));
    store_and_expect(5'd12, link);
    link = pc_now() + 32'd4;
    prog.push_back(j_type(21'd8, 5'd13));
    prog.push_back(s_type(5'd1, 5'd0, bad_off)); // Jumped over
    store_and_expect(5'd13, link);
    branch_case(3'b000, 5'd1, 5'd1, 1'b1);
    branch_case(3'b000, 5'd1, 5'd2, 1'b0);
    branch_case(3'b001, 5'd1, 5'd2, 1'b1);
    branch_case(3'b001, 5'd1, 5'd1, 1'b0);
    branch_case(3'b100, 5'd2, 5'd1, 1'b1);
    branch_case(3'b100, 5'd1, 5'd2, 1'b0);
    branch_case(3'b101, 5'd1, 5'd2, 1'b1);
    branch_case(3'b101, 5'd2, 5'd1, 1'b0);
    branch_case(3'b110, 5'd1, 5'd2, 1'b1);
    branch_case(3'b110, 5'd2, 5'd1, 1'b0);
    branch_case(3'b111, 5'd2, 5'd1, 1'b1);
    branch_case(3'b111, 5'd1, 5'd2, 1'b0);
    prog.push_back(i_type(12'h040, 5'd0, 3'b010, 5'd20, rv_pkg::opc_load)); // lw word 0x10
    prog.push_back(r_type(7'h00, 5'd1, 5'd20, 3'b000, 5'd21));
    store_and_expect(5'd21, 32'h5a4a0074);
    store_and_expect(5'd20, 32'h5a4a0010);
    prog.push_back(i_type(12'd55, 5'd0, 3'b000, 5'd0, rv_pkg::opc_op_imm));
    store_and_expect(5'd0, 32'd0);
    prog.push_back(j_type(21'd0, 5'd0)); // Park in a self loop
  endtask

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(string what, rv_pkg::word_t got, rv_pkg::word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Instruction memory with random stall and ack delay
  always @(posedge clk_i) begin
    ibus_ack_i <= 1'b0;
    ibus_stall_i <= ($random(seed) & 3) == 0;
    if (!reset_ni) begin
      ipend <= 1'b0;
    end else if (ipend) begin
      if (idelay == 2'd0) begin
        ibus_ack_i <= 1'b1;
        ibus_data_i <= (iaddr - reset_pc < 30'(prog.size())) ? prog[iaddr - reset_pc]
                                                             : 32'h00000013;
        ipend <= 1'b0;
      end else begin
        idelay <= idelay - 2'd1;
      end
    end else if (ibus_stb_o && !ibus_stall_i) begin
      ipend <= 1'b1;
      iaddr <= ibus_addr_o;
      idelay <= 2'($random(seed));
    end
  end

  // Data memory, stores go to the observed queue
  always @(posedge clk_i) begin
    dbus_ack_i <= 1'b0;
    dbus_stall_i <= ($random(seed) & 3) == 0;
    if (!reset_ni) begin
      dpend <= 1'b0;
    end else if (dpend) begin
      if (ddelay == 2'd0) begin
        dbus_ack_i <= 1'b1;
        dpend <= 1'b0;
        if (dwe) begin
          dmem[daddr] = dwdata;
          got_addr.push_back(daddr);
          got_data.push_back(dwdata);
        end else begin
          dbus_data_i <= dmem.exists(daddr) ? dmem[daddr] : fill_word(daddr);
        end
      end else begin
        ddelay <= ddelay - 2'd1;
      end
    end else if (dbus_stb_o && !dbus_stall_i) begin
      check_value("dbus sel", {28'b0, dbus_sel_o}, 32'h0000000f); // Word accesses only
      dpend <= 1'b1;
      daddr <= dbus_addr_o;
      dwe <= dbus_we_o;
      dwdata <= dbus_data_o;
      ddelay <= 2'($random(seed));
    end
  end

  task automatic check_buses_idle();
    check_value("ibus cyc/stb", {30'b0, ibus_cyc_o, ibus_stb_o}, 32'd0);
    check_value("dbus cyc/stb", {30'b0, dbus_cyc_o, dbus_stb_o}, 32'd0);
  endtask

  task automatic wait_for_store();
    int n;
    n = 0;
    while (got_addr.size() == 0) begin
      @(negedge clk_i);
      n++;
      if (n > timeout_cycles) fail_run("Timed out waiting for a store on the data bus");
    end
  endtask

  initial begin
    int n;
    reset_ni = 1'b0;
    ibus_ack_i = 1'b0;
    ibus_stall_i = 1'b0;
    ibus_data_i = '0;
    dbus_ack_i = 1'b0;
    dbus_stall_i = 1'b0;
    dbus_data_i = '0;
    build_program();

    repeat (8) begin
      @(negedge clk_i);
      check_buses_idle();
    end
    @(posedge clk_i);
    reset_ni <= 1'b1;
    @(negedge clk_i);
    check_buses_idle(); // First cycle out of reset

    n = 0;
    while (!ibus_stb_o) begin
      @(negedge clk_i);
      n++;
      if (n > timeout_cycles) fail_run("Timed out waiting for the first instruction fetch");
    end
    check_value("first fetch address", {2'b00, ibus_addr_o}, {2'b00, reset_pc});

    for (int i = 0; i < exp_addr.size(); i++) begin
      wait_for_store();
      check_value($sformatf("store %0d address", i), {2'b00, got_addr.pop_front()},
                  {2'b00, exp_addr[i]});
      check_value($sformatf("store %0d data", i), got_data.pop_front(), exp_data[i]);
    end

    repeat (200) @(negedge clk_i); // Room for any extra store to show up
    if (got_addr.size() != 0) begin
      fail_run("An unexpected extra store appeared on the data bus");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: all.f
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_mem.sv
source/rv_core.sv
sim/rv_core_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module rv_core_tb -Mdir obj_dir -f all.f
	./obj_dir/Vrv_core_tb

clean:
	rm -rf obj_dir
